// ==== bench/tb_mdu_pipe.sv ====
// Multiply/divide pipe testbench
// Random operations from an xorshift source checked against a reference model
// Scoreboard in issue order with latency, back-pressure and flush checks

`timescale 1ns/10ps
`default_nettype none

`include "mdu_defs.svh"

module tb_mdu_pipe;

  localparam int NUM_OPS  = 2000;
  localparam int WAIT_MAX = 400;

  logic              clk;
  logic              rst_n;
  logic              flush_i;
  logic              wb_ready_i;
  logic              ready_o;
  mdu_pkg::mdu_exe_t exe_i;
  mdu_pkg::mdu_wb_t  wb_o;

  // Scoreboard, one entry per accepted op
  mdu_pkg::mdu_wb_t  exp_q[$];
  int                acc_cyc_q[$];
  int                lat_q[$];

  logic [31:0]       rng_state;
  int                cycle;
  int                num_acc;
  logic              accepted;
  logic              consumed;
  logic              timing_mode;
  logic              hold_prev;
  mdu_pkg::mdu_wb_t  wb_prev;

  // Inputs applied at the next falling edge
  mdu_pkg::mdu_exe_t nxt_exe;
  logic              nxt_flush;
  logic              nxt_wb_ready;

  mdu_pipe u_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush_i    (flush_i),
    .exe_i      (exe_i),
    .ready_o    (ready_o),
    .wb_o       (wb_o),
    .wb_ready_i (wb_ready_i)
  );

  always #20 clk = ~clk;

  // ============================================================
  // Random source and reference model
  // ============================================================
  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // Corner values a quarter of the time
  function automatic logic [31:0] rand_operand();
    logic [31:0] r;
    logic [31:0] v;
    r = next_rand();
    case (r[3:2])
      2'd0:    v = 32'h0000_0000;
      2'd1:    v = 32'h0000_0001;
      2'd2:    v = 32'hffff_ffff;
      default: v = 32'h8000_0000;
    endcase
    if (r[1:0] != 2'd0) begin
      v = next_rand();
    end
    return v;
  endfunction

  function automatic logic [31:0] model_result(input mdu_pkg::mdu_op_e op, input logic sgn,
                                               input logic [31:0] a, input logic [31:0] b);
    logic [63:0] ea;
    logic [63:0] eb;
    logic [63:0] prod;
    longint      sa;
    longint      sb;
    logic        ovf;
    logic [31:0] res;
    ea   = sgn ? {{32{a[31]}}, a} : {32'h0, a};
    eb   = sgn ? {{32{b[31]}}, b} : {32'h0, b};
    prod = ea * eb;
    sa   = ea;
    sb   = eb;
    // Most negative over minus one
    ovf  = sgn && (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    case (op)
      mdu_pkg::MDU_MUL:  res = prod[31:0];
      mdu_pkg::MDU_MULH: res = prod[63:32];
      mdu_pkg::MDU_DIV:  res = (b == 32'h0) ? 32'hffff_ffff : ovf ? a : 32'(sa / sb);
      default:           res = (b == 32'h0) ? a : ovf ? 32'h0 : 32'(sa % sb);
    endcase
    return res;
  endfunction

  function automatic mdu_pkg::mdu_wb_t expected_wb(input mdu_pkg::mdu_exe_t e);
    mdu_pkg::mdu_wb_t w;
    w.valid = 1'b1;
    w.we    = e.pdest_valid;
    w.pdest = e.pdest;
    w.wdata = model_result(e.op, e.signed_op, e.src0, e.src1);
    return w;
  endfunction

  function automatic mdu_pkg::mdu_exe_t make_exe(input mdu_pkg::mdu_op_e op, input logic sgn,
                                                 input logic [31:0] a, input logic [31:0] b);
    mdu_pkg::mdu_exe_t e;
    logic [31:0]       r;
    r             = next_rand();
    e.valid       = 1'b1;
    e.op          = op;
    e.signed_op   = sgn;
    e.src0        = a;
    e.src1        = b;
    e.pdest_valid = (r[1:0] != 2'd0);
    e.pdest       = r[`MDU_PREG_W+1:2];
    return e;
  endfunction

  function automatic mdu_pkg::mdu_exe_t rand_exe();
    logic [31:0] r;
    logic [31:0] a;
    logic [31:0] b;
    r = next_rand();
    a = rand_operand();
    b = rand_operand();
    return make_exe(mdu_pkg::mdu_op_e'(r[1:0]), r[2], a, b);
  endfunction

  // ============================================================
  // Compare and failure tasks
  // ============================================================
  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic report_timeout(input string what);
    fail_run($sformatf("Timeout while waiting: %s", what));
  endtask

  task automatic check_wb(input string name, input mdu_pkg::mdu_wb_t got,
                          input mdu_pkg::mdu_wb_t exp);
    if (got !== exp) begin
      fail_run($sformatf("** Error: %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_level(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("** Error: %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_latency(input int got, input int exp);
    if (got != exp) begin
      fail_run($sformatf("** Error: wb_o latency got %h expected %h", got, exp));
    end
  endtask

  // ============================================================
  // One clock cycle with scoreboard update
  // ============================================================
  task automatic step();
    @(negedge clk);
    exe_i      = nxt_exe;
    flush_i    = nxt_flush;
    wb_ready_i = nxt_wb_ready;
    #1;
    accepted = 1'b0;
    consumed = 1'b0;
    // Entry waiting on commit must not change
    if (hold_prev) begin
      check_wb("wb_o held", wb_o, wb_prev);
    end
    if (exp_q.size() == 0) begin
      check_level("ready_o", ready_o, 1'b1);
      check_level("wb_o.valid", wb_o.valid, 1'b0);
    end else if (exp_q.size() == 2 && !wb_ready_i) begin
      // Execute and writeback both full
      check_level("ready_o", ready_o, 1'b0);
    end
    if (flush_i) begin
      exp_q.delete();
      acc_cyc_q.delete();
      lat_q.delete();
    end else begin
      if (wb_o.valid && wb_ready_i) begin
        consumed = 1'b1;
        check_wb("wb_o", wb_o, exp_q[0]);
        if (timing_mode) begin
          check_latency(cycle - acc_cyc_q[0] - 1, lat_q[0]);
        end
        void'(exp_q.pop_front());
        void'(acc_cyc_q.pop_front());
        void'(lat_q.pop_front());
      end
      if (exe_i.valid && ready_o) begin
        accepted = 1'b1;
        num_acc++;
        exp_q.push_back(expected_wb(exe_i));
        acc_cyc_q.push_back(cycle);
        lat_q.push_back((exe_i.op == mdu_pkg::MDU_MUL || exe_i.op == mdu_pkg::MDU_MULH) ?
                        2 : `MDU_DIV_ITERS + 2);
      end
      if (exp_q.size() > 2) begin
        fail_run("More than two operations in flight in the pipe");
      end
    end
    hold_prev = wb_o.valid && !wb_ready_i && !flush_i;
    wb_prev   = wb_o;
    cycle++;
  endtask

  // Single op through an empty pipe with commit always ready
  task automatic run_isolated(input mdu_pkg::mdu_exe_t e);
    int n;
    nxt_exe  = e;
    accepted = 1'b0;
    for (n = 0; n < WAIT_MAX && !accepted; n++) begin
      step();
    end
    if (!accepted) begin
      report_timeout("isolated operation never accepted");
    end
    nxt_exe  = '0;
    consumed = 1'b0;
    for (n = 0; n < WAIT_MAX && !consumed; n++) begin
      step();
    end
    if (!consumed) begin
      report_timeout("isolated operation never written back");
    end
  endtask

  // ============================================================
  // Main sequence
  // ============================================================
  initial begin
    int          n;
    int          idle;
    int          stall_left;
    int          gap_left;
    logic [31:0] r;
    clk          = 1'b0;
    rst_n        = 1'b0;
    flush_i      = 1'b0;
    wb_ready_i   = 1'b0;
    exe_i        = '0;
    nxt_exe      = '0;
    nxt_flush    = 1'b0;
    nxt_wb_ready = 1'b1;
    rng_state    = 32'd24036;
    cycle        = 0;
    num_acc      = 0;
    timing_mode  = 1'b0;
    hold_prev    = 1'b0;
    wb_prev      = '0;
    idle         = 0;
    stall_left   = 0;
    gap_left     = 0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    #1;
    // Idle state straight out of reset
    check_level("ready_o", ready_o, 1'b1);
    check_level("wb_o.valid", wb_o.valid, 1'b0);

    // Exact latency and the division corner cases
    timing_mode = 1'b1;
    run_isolated(make_exe(mdu_pkg::MDU_DIV, 1'b1, 32'h8000_0000, 32'hffff_ffff));
    run_isolated(make_exe(mdu_pkg::MDU_REM, 1'b1, 32'h8000_0000, 32'hffff_ffff));
    run_isolated(make_exe(mdu_pkg::MDU_DIV, 1'b0, 32'h1234_5678, 32'h0));
    run_isolated(make_exe(mdu_pkg::MDU_REM, 1'b1, 32'hffff_fff9, 32'h0));
    run_isolated(make_exe(mdu_pkg::MDU_MUL, 1'b1, 32'hffff_fff9, 32'h3));
    run_isolated(make_exe(mdu_pkg::MDU_MULH, 1'b1, 32'h8000_0000, 32'h8000_0000));
    run_isolated(make_exe(mdu_pkg::MDU_MULH, 1'b0, 32'hffff_ffff, 32'hffff_ffff));
    run_isolated(make_exe(mdu_pkg::MDU_DIV, 1'b1, 32'hffff_fff9, 32'h2));
    run_isolated(make_exe(mdu_pkg::MDU_REM, 1'b1, 32'hffff_fff9, 32'h2));
    repeat (8) run_isolated(rand_exe());
    timing_mode = 1'b0;

    // Random traffic with back-pressure and flushes
    while (num_acc < NUM_OPS) begin
      r = next_rand();
      if (stall_left > 0) begin
        stall_left--;
      end else if (r[12:8] == 5'd0) begin
        // Long commit stall
        stall_left = 8 + int'(r[18:13]);
      end
      nxt_flush    = (r[7:0] == 8'd0);
      nxt_wb_ready = (stall_left == 0) && ((next_rand() % 32'd3) != 32'd0);
      if (nxt_flush) begin
        nxt_exe      = '0;
        nxt_wb_ready = 1'b0;
      end else if (!nxt_exe.valid) begin
        if (gap_left > 0) begin
          gap_left--;
        end else begin
          nxt_exe = rand_exe();
        end
      end
      step();
      if (accepted) begin
        nxt_exe  = '0;
        gap_left = (r[22:21] == 2'd0) ? int'(r[25:23]) : 0;
        idle     = 0;
      end else begin
        idle++;
      end
      if (idle > WAIT_MAX) begin
        report_timeout("no operation accepted by the pipe");
      end
    end

    // Drain what is still in flight
    nxt_exe      = '0;
    nxt_flush    = 1'b0;
    nxt_wb_ready = 1'b1;
    for (n = 0; n < WAIT_MAX && exp_q.size() != 0; n++) begin
      step();
    end
    if (exp_q.size() != 0) begin
      report_timeout("pipe did not drain at the end");
    end
    $display("TB PASSED");
    $finish;
  end

endmodule : tb_mdu_pipe

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the multiply/divide pipe testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module tb_mdu_pipe -f tb.f -o sim_tb_mdu_pipe

# A fatal stop exits non-zero, so the log decides the result
./obj_dir/sim_tb_mdu_pipe > sim.log 2>&1 || true
cat sim.log

if grep -q "TB FAILED" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi
if ! grep -q "TB PASSED" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi

// ==== src/mdu_ctrl.sv ====
// Multiply/divide pipe control
// Execute-stage register, unit start pulses, result select and writeback register

`timescale 1ns/10ps
`default_nettype none

`include "mdu_defs.svh"

module mdu_ctrl (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire                     flush_i,
  input  mdu_pkg::mdu_exe_t       exe_i,
  output logic                    ready_o,
  output mdu_pkg::mdu_mult_req_t  mult_req_o,
  output mdu_pkg::mdu_div_req_t   div_req_o,
  input  mdu_pkg::mdu_mult_rsp_t  mult_rsp_i,
  input  mdu_pkg::mdu_div_rsp_t   div_rsp_i,
  output mdu_pkg::mdu_wb_t        wb_o,
  input  wire                     wb_ready_i
);

  mdu_pkg::mdu_exe_t    exe_q;
  mdu_pkg::mdu_wb_t     wb_q;
  logic                 started_q;
  logic                 held_q;
  logic [`MDU_XLEN-1:0] held_data_q;

  logic                 is_mul;
  logic                 start;
  logic                 fu_done;
  logic [`MDU_XLEN-1:0] res_sel;
  logic [`MDU_XLEN-1:0] res_word;
  logic                 wb_free;
  logic                 exe_advance;

  // ============================================================
  // Execute stage
  // ============================================================
  always_comb begin
    is_mul = (exe_q.op == mdu_pkg::MDU_MUL) || (exe_q.op == mdu_pkg::MDU_MULH);
    // First cycle in the stage only
    start  = exe_q.valid & ~started_q;

    mult_req_o.valid        = start & is_mul;
    mult_req_o.mul_signed   = exe_q.signed_op;
    mult_req_o.multiplicand = exe_q.src0;
    mult_req_o.multiplier   = exe_q.src1;

    div_req_o.valid      = start & ~is_mul;
    div_req_o.flush      = flush_i;
    div_req_o.div_signed = exe_q.signed_op;
    div_req_o.dividend   = exe_q.src0;
    div_req_o.divisor    = exe_q.src1;

    // Ignore unit pulses until this op has started
    fu_done = started_q & (is_mul ? mult_rsp_i.valid : div_rsp_i.valid);

    case (exe_q.op)
      mdu_pkg::MDU_MUL:  res_sel = mult_rsp_i.res_lo;
      mdu_pkg::MDU_MULH: res_sel = mult_rsp_i.res_hi;
      mdu_pkg::MDU_DIV:  res_sel = div_rsp_i.quotient;
      default:           res_sel = div_rsp_i.remainder;
    endcase
    res_word = held_q ? held_data_q : res_sel;

    // Writeback empty or draining this edge
    wb_free     = ~wb_q.valid | wb_ready_i;
    exe_advance = exe_q.valid & (held_q | fu_done) & wb_free;
    ready_o     = ~exe_q.valid | exe_advance;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      exe_q     <= '0;
      started_q <= 1'b0;
      held_q    <= 1'b0;
    end else if (flush_i) begin
      exe_q.valid <= 1'b0;
      started_q   <= 1'b0;
      held_q      <= 1'b0;
    end else if (ready_o) begin
      // Stage refills or empties
      exe_q     <= exe_i;
      started_q <= 1'b0;
      held_q    <= 1'b0;
    end else begin
      if (start) begin
        started_q <= 1'b1;
      end
      // Result parked while writeback is full
      if (fu_done) begin
        held_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fu_done) begin
      held_data_q <= res_sel;
    end
  end

  // ============================================================
  // Writeback register
  // ============================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_q <= '0;
    end else if (flush_i) begin
      wb_q.valid <= 1'b0;
    end else if (wb_free) begin
      wb_q.valid <= exe_advance;
      if (exe_advance) begin
        wb_q.we    <= exe_q.pdest_valid;
        wb_q.pdest <= exe_q.pdest;
        wb_q.wdata <= res_word;
      end
    end
  end

  assign wb_o = wb_q;

endmodule : mdu_ctrl

`default_nettype wire

// ==== src/mdu_defs.svh ====
// Multiply/divide pipe sizing
// Data width, destination tag width, divider step count and product width

`ifndef MDU_DEFS_SVH
`define MDU_DEFS_SVH

// ============================================================
// Datapath
// ============================================================

// Operand and result width
`define MDU_XLEN 32

// Full product width of the multiplier
`define MDU_PROD_W (2 * `MDU_XLEN)

// Physical register tag width
`define MDU_PREG_W 6

// One quotient bit per divider cycle
`define MDU_DIV_ITERS 32

`endif

// ==== src/mdu_div.sv ====
// Iterative restoring divider
// Works on magnitudes, one quotient bit per cycle, signs fixed on the way out
// Zero divisor and overflow follow the RISC-V results, flush aborts at once

`timescale 1ns/10ps
`default_nettype none

`include "mdu_defs.svh"

module mdu_div (
  input  wire                    clk,
  input  wire                    rst_n,
  input  mdu_pkg::mdu_div_req_t  div_req_i,
  output mdu_pkg::mdu_div_rsp_t  div_rsp_o
);

  localparam int CNT_W = $clog2(`MDU_DIV_ITERS);

  // Control state
  logic             busy_q;
  logic             fin_q;
  logic [CNT_W-1:0] cnt_q;

  // Datapath state
  logic [`MDU_XLEN-1:0] rem_q;
  logic [`MDU_XLEN-1:0] quo_q;
  logic [`MDU_XLEN-1:0] dvs_q;
  logic [`MDU_XLEN-1:0] dividend_q;
  logic                 neg_quo_q;
  logic                 neg_rem_q;
  logic                 dvz_q;

  // Start-time operand decode
  logic                 a_neg;
  logic                 b_neg;
  logic [`MDU_XLEN-1:0] a_mag;
  logic [`MDU_XLEN-1:0] b_mag;

  // One shift-subtract step
  logic [`MDU_XLEN:0]   shifted;
  logic [`MDU_XLEN+1:0] diff;
  logic                 q_bit;

  always_comb begin
    a_neg = div_req_i.div_signed & div_req_i.dividend[`MDU_XLEN-1];
    b_neg = div_req_i.div_signed & div_req_i.divisor[`MDU_XLEN-1];
    a_mag = a_neg ? -div_req_i.dividend : div_req_i.dividend;
    b_mag = b_neg ? -div_req_i.divisor : div_req_i.divisor;
    // Bring down the next dividend bit
    shifted = {rem_q, quo_q[`MDU_XLEN-1]};
    diff    = {1'b0, shifted} - {2'b00, dvs_q};
    // Non-negative difference sets the quotient bit
    q_bit   = ~diff[`MDU_XLEN+1];
  end

  // ============================================================
  // Sequencing
  // ============================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
      fin_q  <= 1'b0;
      cnt_q  <= '0;
    end else if (div_req_i.flush) begin
      busy_q <= 1'b0;
      fin_q  <= 1'b0;
      cnt_q  <= '0;
    end else if (div_req_i.valid) begin
      busy_q <= 1'b1;
      fin_q  <= 1'b0;
      cnt_q  <= '0;
    end else if (busy_q) begin
      cnt_q <= cnt_q + 1'b1;
      // Last step, result shown next cycle
      if (cnt_q == CNT_W'(`MDU_DIV_ITERS - 1)) begin
        busy_q <= 1'b0;
        fin_q  <= 1'b1;
      end
    end else begin
      fin_q <= 1'b0;
    end
  end

  // ============================================================
  // Shift-subtract datapath
  // ============================================================
  always_ff @(posedge clk) begin
    if (div_req_i.valid) begin
      rem_q      <= '0;
      quo_q      <= a_mag;
      dvs_q      <= b_mag;
      dividend_q <= div_req_i.dividend;
      neg_quo_q  <= a_neg ^ b_neg;
      neg_rem_q  <= a_neg;
      dvz_q      <= (div_req_i.divisor == '0);
    end else if (busy_q) begin
      rem_q <= q_bit ? diff[`MDU_XLEN-1:0] : shifted[`MDU_XLEN-1:0];
      quo_q <= {quo_q[`MDU_XLEN-2:0], q_bit};
    end
  end

  // Sign fix and zero-divisor override
  always_comb begin
    div_rsp_o.valid     = fin_q;
    div_rsp_o.busy      = busy_q;
    div_rsp_o.quotient  = neg_quo_q ? -quo_q : quo_q;
    div_rsp_o.remainder = neg_rem_q ? -rem_q : rem_q;
    if (dvz_q) begin
      div_rsp_o.quotient  = '1;
      div_rsp_o.remainder = dividend_q;
    end
  end

endmodule : mdu_div

`default_nettype wire

// ==== src/mdu_mult.sv ====
// Registered 32x32 multiplier
// Signed or unsigned product, both words returned one cycle after the request

`timescale 1ns/10ps
`default_nettype none

`include "mdu_defs.svh"

module mdu_mult (
  input  wire                     clk,
  input  wire                     rst_n,
  input  mdu_pkg::mdu_mult_req_t  mult_req_i,
  output mdu_pkg::mdu_mult_rsp_t  mult_rsp_o
);

  // One extra bit so unsigned operands stay positive
  logic signed [`MDU_XLEN:0]       a_ext;
  logic signed [`MDU_XLEN:0]       b_ext;
  logic signed [2*`MDU_XLEN+1:0]   prod_full;
  logic        [`MDU_PROD_W-1:0]   prod_q;
  logic                            valid_q;

  // ============================================================
  // Operand extension and product
  // ============================================================
  always_comb begin
    a_ext = {mult_req_i.mul_signed & mult_req_i.multiplicand[`MDU_XLEN-1],
             mult_req_i.multiplicand};
    b_ext = {mult_req_i.mul_signed & mult_req_i.multiplier[`MDU_XLEN-1],
             mult_req_i.multiplier};
    prod_full = a_ext * b_ext;
  end

  // Done pulse follows the start pulse by one cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= mult_req_i.valid;
    end
  end

  // Product captured on start only
  always_ff @(posedge clk) begin
    if (mult_req_i.valid) begin
      prod_q <= prod_full[`MDU_PROD_W-1:0];
    end
  end

  always_comb begin
    mult_rsp_o.valid  = valid_q;
    mult_rsp_o.res_lo = prod_q[`MDU_XLEN-1:0];
    mult_rsp_o.res_hi = prod_q[`MDU_PROD_W-1:`MDU_XLEN];
  end

endmodule : mdu_mult

`default_nettype wire

// ==== src/mdu_pipe.sv ====
// Multiply/divide pipe top
// Control stage feeding a registered multiplier and an iterative divider

`timescale 1ns/10ps
`default_nettype none

module mdu_pipe (
  input  wire                clk,
  input  wire                rst_n,
  input  wire                flush_i,
  input  mdu_pkg::mdu_exe_t  exe_i,
  output logic               ready_o,
  output mdu_pkg::mdu_wb_t   wb_o,
  input  wire                wb_ready_i
);

  // Unit request and response buses
  mdu_pkg::mdu_mult_req_t mult_req;
  mdu_pkg::mdu_mult_rsp_t mult_rsp;
  mdu_pkg::mdu_div_req_t  div_req;
  mdu_pkg::mdu_div_rsp_t  div_rsp;

  mdu_ctrl u_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush_i    (flush_i),
    .exe_i      (exe_i),
    .ready_o    (ready_o),
    .mult_req_o (mult_req),
    .div_req_o  (div_req),
    .mult_rsp_i (mult_rsp),
    .div_rsp_i  (div_rsp),
    .wb_o       (wb_o),
    .wb_ready_i (wb_ready_i)
  );

  mdu_mult u_mult (
    .clk        (clk),
    .rst_n      (rst_n),
    .mult_req_i (mult_req),
    .mult_rsp_o (mult_rsp)
  );

  mdu_div u_div (
    .clk       (clk),
    .rst_n     (rst_n),
    .div_req_i (div_req),
    .div_rsp_o (div_rsp)
  );

endmodule : mdu_pipe

`default_nettype wire

// ==== src/mdu_pkg.sv ====
// Multiply/divide pipe types
// Opcode enum and the packed structs passed between the pipe blocks

`default_nettype none

`include "mdu_defs.svh"

package mdu_pkg;

  // ============================================================
  // Opcodes
  // ============================================================
  typedef enum logic [1:0] {
    MDU_MUL  = 2'd0,
    MDU_MULH = 2'd1,
    MDU_DIV  = 2'd2,
    MDU_REM  = 2'd3
  } mdu_op_e;

  // ============================================================
  // Pipe boundary
  // ============================================================

  // Issued operation from the scheduler
  typedef struct packed {
    logic                   valid;
    mdu_op_e                op;
    logic                   signed_op;
    logic [`MDU_XLEN-1:0]   src0;
    logic [`MDU_XLEN-1:0]   src1;
    logic                   pdest_valid;
    logic [`MDU_PREG_W-1:0] pdest;
  } mdu_exe_t;

  // Result handed to commit
  typedef struct packed {
    logic                   valid;
    logic                   we;
    logic [`MDU_PREG_W-1:0] pdest;
    logic [`MDU_XLEN-1:0]   wdata;
  } mdu_wb_t;

  // ============================================================
  // Functional units
  // ============================================================
  typedef struct packed {
    logic                 valid;
    logic                 mul_signed;
    logic [`MDU_XLEN-1:0] multiplicand;
    logic [`MDU_XLEN-1:0] multiplier;
  } mdu_mult_req_t;

  typedef struct packed {
    logic                 valid;
    logic [`MDU_XLEN-1:0] res_lo;
    logic [`MDU_XLEN-1:0] res_hi;
  } mdu_mult_rsp_t;

  typedef struct packed {
    logic                 valid;
    logic                 flush;
    logic                 div_signed;
    logic [`MDU_XLEN-1:0] dividend;
    logic [`MDU_XLEN-1:0] divisor;
  } mdu_div_req_t;

  typedef struct packed {
    logic                 valid;
    logic                 busy;
    logic [`MDU_XLEN-1:0] quotient;
    logic [`MDU_XLEN-1:0] remainder;
  } mdu_div_rsp_t;

endpackage : mdu_pkg

`default_nettype wire

// ==== tb.f ====
+incdir+src
src/mdu_pkg.sv
src/mdu_mult.sv
src/mdu_div.sv
src/mdu_ctrl.sv
src/mdu_pipe.sv
bench/tb_mdu_pipe.sv
